/* Bender.yml */
package:
  name: cpu

sources:
  - hdl/cpu_pkg.sv
  - hdl/cpu_dec_if.sv
  - hdl/cpu_res_if.sv
  - hdl/cpu_regfile.sv
  - hdl/cpu_control.sv
  - hdl/cpu_decode.sv
  - hdl/cpu_execute.sv
  - hdl/cpu_result.sv
  - hdl/cpu_top.sv
  - target: simulation
    include_dirs:
      - tb
    files:
      - tb/cpu_tb.sv

/* hdl/cpu_control.sv */
`timescale 1ns/1ps

module cpu_control import cpu_pkg::*; (
    input  logic                      clk_i,
    input  logic                      rst_i,
    cpu_dec_if.ctl                    dec,
    input  logic [DATA_W-1:0]         pc_i,
    input  logic [DATA_W-1:0]         mem_adr_i,
    input  logic [DATA_W-1:0]         mem_wdata_i,
    input  logic                      bus_ack_i,
    input  logic                      bus_err_i,
    output logic                      bus_cyc_o,
    output logic                      bus_stb_o,
    output logic                      bus_we_o,
    output logic [BYTES_PER_WORD-1:0] bus_sel_o,
    output logic [DATA_W-1:0]         bus_adr_o,
    output logic [DATA_W-1:0]         bus_dat_o,
    output logic                      fetch_done_o,
    output logic                      instr_load_o,
    output logic                      commit_o,
    output logic                      halted_o
);

    cpu_state_e state_q;
    logic       bus_open_q;  // cyc and stb
    logic       mem_op;
    logic       fetch_ack;

    assign mem_op = (dec.opcode == OP_LOAD) || (dec.opcode == OP_STORE);

    ////////////////////
    // State machine

    always_ff @(posedge clk_i) begin
        if (rst_i) begin
            state_q    <= ST_FETCH;
            bus_open_q <= 1'b0;
        end else begin
            case (state_q)
                ST_FETCH: begin
                    if (!bus_open_q) begin
                        bus_open_q <= 1'b1;  // First fetch after reset
                    end else if (bus_err_i) begin
                        state_q    <= ST_HALT;
                        bus_open_q <= 1'b0;
                    end else if (bus_ack_i) begin
                        state_q    <= ST_DECODE;
                        bus_open_q <= 1'b0;
                    end
                end
                ST_DECODE: begin
                    if (!dec.cond_met) begin
                        state_q <= ST_WRITEBACK;  // Skipped, nothing commits
                    end else begin
                        state_q    <= ST_EXECUTE;
                        bus_open_q <= mem_op;
                    end
                end
                ST_EXECUTE: begin
                    if (dec.opcode == OP_HALT) begin
                        state_q <= ST_HALT;
                    end else if (!mem_op) begin
                        state_q <= ST_WRITEBACK;
                    end else if (bus_err_i) begin
                        state_q    <= ST_HALT;
                        bus_open_q <= 1'b0;
                    end else if (bus_ack_i) begin
                        state_q    <= ST_WRITEBACK;
                        bus_open_q <= 1'b0;
                    end
                end
                ST_WRITEBACK: begin
                    // PC written this cycle is on pc_i when the fetch opens
                    state_q    <= ST_FETCH;
                    bus_open_q <= 1'b1;
                end
                ST_HALT: begin
                    state_q <= ST_HALT;  // Left only by reset
                end
                default: begin
                    state_q    <= ST_HALT;
                    bus_open_q <= 1'b0;
                end
            endcase
        end
    end

    ////////////////////
    // Bus outputs

    assign bus_cyc_o = bus_open_q;
    assign bus_stb_o = bus_open_q;
    assign bus_we_o  = bus_open_q && (state_q == ST_EXECUTE) && (dec.opcode == OP_STORE);
    assign bus_sel_o = SEL_ALL;
    assign bus_adr_o = (state_q == ST_EXECUTE) ? mem_adr_i : pc_i;
    assign bus_dat_o = mem_wdata_i;

    assign fetch_ack    = (state_q == ST_FETCH) && bus_open_q && bus_ack_i;
    assign instr_load_o = fetch_ack;
    assign fetch_done_o = fetch_ack;
    assign commit_o     = (state_q == ST_WRITEBACK);
    assign halted_o     = (state_q == ST_HALT);

endmodule

/* hdl/cpu_dec_if.sv */
`timescale 1ns/1ps

interface cpu_dec_if import cpu_pkg::*; ();

    opcode_e               opcode;
    format_e               fmt;
    logic [REG_ID_W-1:0]   reg_a;
    logic [REG_ID_W-1:0]   reg_b;
    logic [IMM_W-1:0]      imm;
    logic [SHAMT_W-1:0]    shamt;
    logic [OFF_W-1:0]      off;
    logic [JIMM_W-1:0]     jimm;
    logic                  cond_met;  // Condition code allows execution

    modport dec (output opcode, fmt, reg_a, reg_b, imm, shamt, off, jimm, cond_met);
    modport exe (input opcode, fmt, reg_a, reg_b, imm, shamt, off, jimm, cond_met);
    modport ctl (input opcode, cond_met);

endinterface

/* hdl/cpu_decode.sv */
`timescale 1ns/1ps

module cpu_decode import cpu_pkg::*; (
    input  logic              clk_i,
    input  logic              rst_i,
    input  logic              instr_load_i,
    input  logic [DATA_W-1:0] bus_dat_i,
    input  logic              zero_i,
    cpu_dec_if.dec            dec
);

    logic [DATA_W-1:0] instr_q;
    cond_e             cond;

    // Instruction register, cleared to a nop
    always_ff @(posedge clk_i) begin
        if (rst_i) begin
            instr_q <= '0;
        end else if (instr_load_i) begin
            instr_q <= bus_dat_i;
        end
    end

    ////////////////////
    // Field split

    assign dec.opcode = opcode_e'(instr_q[OPC_MSB:OPC_LSB]);
    assign dec.fmt    = format_e'(instr_q[FMT_MSB:FMT_LSB]);
    assign cond       = cond_e'(instr_q[COND_MSB:COND_LSB]);

    assign dec.reg_a  = instr_q[RA_MSB:RA_LSB];
    assign dec.reg_b  = instr_q[RB_MSB:RB_LSB];    // RRO only
    assign dec.imm    = instr_q[IMM_MSB:IMM_LSB];  // Overlaps reg_b
    assign dec.shamt  = instr_q[SHAMT_MSB:SHAMT_LSB];
    assign dec.off    = instr_q[OFF_MSB:OFF_LSB];
    assign dec.jimm   = instr_q[JIMM_MSB:JIMM_LSB];

    // Condition against the zero flag
    always_comb begin
        case (cond)
            COND_Z:  dec.cond_met = zero_i;
            COND_NZ: dec.cond_met = !zero_i;
            default: dec.cond_met = 1'b1;  // Unknown codes run unconditionally
        endcase
    end

endmodule

/* hdl/cpu_execute.sv */
`timescale 1ns/1ps

module cpu_execute import cpu_pkg::*; (
    cpu_dec_if.exe              dec,
    input  logic [DATA_W-1:0]   rd_a_i,
    input  logic [DATA_W-1:0]   rd_b_i,
    input  logic [DATA_W-1:0]   bus_dat_i,
    cpu_res_if.exe              res,
    output logic [REG_ID_W-1:0] rd_a_id_o,
    output logic [REG_ID_W-1:0] rd_b_id_o,
    output logic [DATA_W-1:0]   mem_adr_o,
    output logic [DATA_W-1:0]   mem_wdata_o
);

    logic [DATA_W-1:0] imm_ext;
    logic [DATA_W-1:0] off_ext;
    logic [DATA_W-1:0] jimm_ext;
    logic [DATA_W-1:0] sub_res;
    logic [DATA_W-1:0] bit_mask;

    assign rd_a_id_o = dec.reg_a;
    assign rd_b_id_o = dec.reg_b;

    assign imm_ext  = {{(DATA_W-IMM_W){1'b0}}, dec.imm};
    assign off_ext  = {{(DATA_W-OFF_W){1'b0}}, dec.off};
    assign jimm_ext = {{(DATA_W-JIMM_W){1'b0}}, dec.jimm};
    assign sub_res  = rd_a_i - imm_ext;
    assign bit_mask = {{(DATA_W-1){1'b0}}, 1'b1} << dec.imm;

    ////////////////////
    // Memory address and store data

    assign mem_adr_o   = (dec.opcode == OP_LOAD) ? rd_b_i + off_ext : rd_a_i + off_ext;
    assign mem_wdata_o = rd_b_i;

    ////////////////////
    // Result request

    always_comb begin
        res.wr_en    = 1'b0;
        res.wr_id    = dec.reg_a;
        res.wr_data  = '0;
        res.flag_en  = 1'b0;
        res.flag_val = 1'b0;
        if (dec.cond_met) begin
            case (dec.opcode)
                OP_SET: begin
                    res.wr_en   = 1'b1;
                    res.wr_data = (dec.fmt == FMT_RIS) ? imm_ext << dec.shamt : rd_b_i;
                end
                OP_SUB: begin
                    res.wr_en    = 1'b1;
                    res.wr_data  = sub_res;
                    res.flag_en  = 1'b1;
                    res.flag_val = (sub_res == '0);
                end
                OP_SHIFTL: begin
                    res.wr_en   = 1'b1;
                    res.wr_data = rd_a_i << dec.imm;
                end
                OP_OR:  begin res.wr_en = 1'b1; res.wr_data = rd_a_i | rd_b_i; end
                OP_AND: begin res.wr_en = 1'b1; res.wr_data = rd_a_i & rd_b_i; end
                OP_XOR: begin res.wr_en = 1'b1; res.wr_data = rd_a_i ^ rd_b_i; end
                OP_TESTBIT: begin
                    res.flag_en  = 1'b1;
                    res.flag_val = ((rd_a_i & bit_mask) == '0);  // Set when bit clear
                end
                OP_JUMP: begin
                    res.wr_en   = 1'b1;
                    res.wr_id   = REG_ID_W'(REG_PC);
                    res.wr_data = (dec.fmt == FMT_I) ? jimm_ext : rd_a_i;
                end
                OP_LOAD: begin
                    res.wr_en   = 1'b1;
                    res.wr_data = bus_dat_i;  // Valid on the data ack
                end
                default: ;  // nop, store, halt
            endcase
        end
    end

endmodule

/* hdl/cpu_pkg.sv */
package cpu_pkg;

    ////////////////////
    // Widths and register numbers

    localparam int unsigned DATA_W         = 64;
    localparam int unsigned BYTES_PER_WORD = DATA_W / 8;  // PC step
    localparam int unsigned REG_ID_W       = 5;
    localparam int unsigned REG_ZERO       = 0;
    localparam int unsigned REG_PC         = 31;

    localparam logic [DATA_W-1:0] PC_RESET = 64'h0000_8000_0000_0000;  // Boot ROM
    localparam logic [BYTES_PER_WORD-1:0] SEL_ALL = 8'hff;

    localparam int unsigned IMM_W   = 41;
    localparam int unsigned OFF_W   = 41;
    localparam int unsigned JIMM_W  = 51;
    localparam int unsigned SHAMT_W = 5;

    ////////////////////
    // Instruction field positions

    localparam int unsigned OPC_MSB   = 63;
    localparam int unsigned OPC_LSB   = 57;
    localparam int unsigned FMT_MSB   = 56;
    localparam int unsigned FMT_LSB   = 55;
    localparam int unsigned COND_MSB  = 54;
    localparam int unsigned COND_LSB  = 51;
    localparam int unsigned RA_MSB    = 50;
    localparam int unsigned RA_LSB    = 46;
    localparam int unsigned RB_MSB    = 45;
    localparam int unsigned RB_LSB    = 41;
    localparam int unsigned IMM_MSB   = 45;
    localparam int unsigned IMM_LSB   = 5;
    localparam int unsigned OFF_MSB   = 40;
    localparam int unsigned OFF_LSB   = 0;
    localparam int unsigned SHAMT_MSB = 4;
    localparam int unsigned SHAMT_LSB = 0;
    localparam int unsigned JIMM_MSB  = 50;
    localparam int unsigned JIMM_LSB  = 0;

    ////////////////////
    // Encodings

    typedef enum logic [6:0] {
        OP_NOP     = 7'h00,
        OP_SET     = 7'h01,
        OP_LOAD    = 7'h02,
        OP_STORE   = 7'h03,
        OP_JUMP    = 7'h04,
        OP_TESTBIT = 7'h05,
        OP_SUB     = 7'h06,
        OP_SHIFTL  = 7'h07,
        OP_OR      = 7'h08,
        OP_AND     = 7'h09,
        OP_XOR     = 7'h0a,
        OP_HALT    = 7'h7f
    } opcode_e;

    typedef enum logic [1:0] {
        FMT_RRO = 2'b00,  // Register, register, offset
        FMT_RIS = 2'b01,  // Register, immediate, shift
        FMT_I   = 2'b10
    } format_e;

    typedef enum logic [3:0] {
        COND_ALWAYS = 4'b0000,
        COND_Z      = 4'b0001,
        COND_NZ     = 4'b1001
    } cond_e;

    typedef enum logic [2:0] {
        ST_FETCH,
        ST_DECODE,
        ST_EXECUTE,
        ST_WRITEBACK,
        ST_HALT
    } cpu_state_e;

endpackage

/* hdl/cpu_regfile.sv */
`timescale 1ns/1ps

module cpu_regfile import cpu_pkg::*; (
    input  logic                clk_i,
    input  logic                rst_i,
    input  logic                we_i,
    input  logic [REG_ID_W-1:0] wr_id_i,
    input  logic [DATA_W-1:0]   wr_data_i,
    input  logic [REG_ID_W-1:0] rd_a_id_i,
    input  logic [REG_ID_W-1:0] rd_b_id_i,
    output logic [DATA_W-1:0]   rd_a_o,
    output logic [DATA_W-1:0]   rd_b_o,
    output logic [DATA_W-1:0]   pc_o
);

    logic [DATA_W-1:0] regs_q [REG_ZERO:REG_PC];

    always_ff @(posedge clk_i) begin
        if (rst_i) begin
            for (int i = REG_ZERO; i < REG_PC; i++) begin
                regs_q[i] <= '0;
            end
            regs_q[REG_PC] <= PC_RESET;  // Start in boot ROM
        end else if (we_i) begin
            regs_q[wr_id_i] <= wr_data_i;
        end
    end

    // Combinational read ports
    assign rd_a_o = regs_q[rd_a_id_i];
    assign rd_b_o = regs_q[rd_b_id_i];
    assign pc_o   = regs_q[REG_PC];

endmodule

/* hdl/cpu_res_if.sv */
`timescale 1ns/1ps

interface cpu_res_if import cpu_pkg::*; ();

    // Register write request
    logic                wr_en;
    logic [REG_ID_W-1:0] wr_id;
    logic [DATA_W-1:0]   wr_data;

    // Zero flag update
    logic                flag_en;
    logic                flag_val;

    modport exe (output wr_en, wr_id, wr_data, flag_en, flag_val);
    modport res (input wr_en, wr_id, wr_data, flag_en, flag_val);

endinterface

/* hdl/cpu_result.sv */
`timescale 1ns/1ps

module cpu_result import cpu_pkg::*; (
    input  logic                clk_i,
    input  logic                rst_i,
    cpu_res_if.res              res,
    input  logic                commit_i,
    input  logic                fetch_done_i,
    input  logic [DATA_W-1:0]   pc_i,
    output logic                zero_o,
    output logic                rf_we_o,
    output logic [REG_ID_W-1:0] rf_id_o,
    output logic [DATA_W-1:0]   rf_data_o
);

    logic                wr_en_q;
    logic                flag_en_q;
    logic [REG_ID_W-1:0] wr_id_q;
    logic [DATA_W-1:0]   wr_data_q;
    logic                flag_val_q;
    logic                zero_q;

    // Request from the last execute cycle, load data is only there on its ack
    always_ff @(posedge clk_i) begin
        wr_id_q    <= res.wr_id;
        wr_data_q  <= res.wr_data;
        flag_val_q <= res.flag_val;
    end

    always_ff @(posedge clk_i) begin
        if (rst_i) begin
            wr_en_q   <= 1'b0;
            flag_en_q <= 1'b0;
            zero_q    <= 1'b0;
        end else begin
            wr_en_q   <= res.wr_en;
            flag_en_q <= res.flag_en;
            if (commit_i && flag_en_q) begin
                zero_q <= flag_val_q;
            end
        end
    end

    // Fetch and write-back never share a cycle
    assign rf_we_o   = fetch_done_i || (commit_i && wr_en_q);
    assign rf_id_o   = fetch_done_i ? REG_ID_W'(REG_PC) : wr_id_q;
    assign rf_data_o = fetch_done_i ? pc_i + BYTES_PER_WORD : wr_data_q;
    assign zero_o    = zero_q;

endmodule

/* hdl/cpu_top.sv */
`timescale 1ns/1ps

module cpu_top import cpu_pkg::*; (
    input  logic                      clk_i,
    input  logic                      rst_i,
    output logic                      halted_o,
    output logic                      bus_cyc_o,
    output logic                      bus_stb_o,
    output logic                      bus_we_o,
    output logic [BYTES_PER_WORD-1:0] bus_sel_o,
    output logic [DATA_W-1:0]         bus_adr_o,
    output logic [DATA_W-1:0]         bus_dat_o,
    input  logic [DATA_W-1:0]         bus_dat_i,
    input  logic                      bus_ack_i,
    input  logic                      bus_err_i
);

    logic [DATA_W-1:0]   pc;
    logic [DATA_W-1:0]   rd_a;
    logic [DATA_W-1:0]   rd_b;
    logic [REG_ID_W-1:0] rd_a_id;
    logic [REG_ID_W-1:0] rd_b_id;
    logic [DATA_W-1:0]   mem_adr;
    logic [DATA_W-1:0]   mem_wdata;
    logic                fetch_done;
    logic                instr_load;
    logic                commit;
    logic                zero;
    logic                rf_we;
    logic [REG_ID_W-1:0] rf_id;
    logic [DATA_W-1:0]   rf_data;

    cpu_dec_if dec_if ();
    cpu_res_if res_if ();

    cpu_control u_control (
        .clk_i        (clk_i),
        .rst_i        (rst_i),
        .dec          (dec_if.ctl),
        .pc_i         (pc),
        .mem_adr_i    (mem_adr),
        .mem_wdata_i  (mem_wdata),
        .bus_ack_i    (bus_ack_i),
        .bus_err_i    (bus_err_i),
        .bus_cyc_o    (bus_cyc_o),
        .bus_stb_o    (bus_stb_o),
        .bus_we_o     (bus_we_o),
        .bus_sel_o    (bus_sel_o),
        .bus_adr_o    (bus_adr_o),
        .bus_dat_o    (bus_dat_o),
        .fetch_done_o (fetch_done),
        .instr_load_o (instr_load),
        .commit_o     (commit),
        .halted_o     (halted_o)
    );

    cpu_decode u_decode (
        .clk_i        (clk_i),
        .rst_i        (rst_i),
        .instr_load_i (instr_load),
        .bus_dat_i    (bus_dat_i),
        .zero_i       (zero),
        .dec          (dec_if.dec)
    );

    cpu_execute u_execute (
        .dec          (dec_if.exe),
        .rd_a_i       (rd_a),
        .rd_b_i       (rd_b),
        .bus_dat_i    (bus_dat_i),
        .res          (res_if.exe),
        .rd_a_id_o    (rd_a_id),
        .rd_b_id_o    (rd_b_id),
        .mem_adr_o    (mem_adr),
        .mem_wdata_o  (mem_wdata)
    );

    cpu_result u_result (
        .clk_i        (clk_i),
        .rst_i        (rst_i),
        .res          (res_if.res),
        .commit_i     (commit),
        .fetch_done_i (fetch_done),
        .pc_i         (pc),
        .zero_o       (zero),
        .rf_we_o      (rf_we),
        .rf_id_o      (rf_id),
        .rf_data_o    (rf_data)
    );

    cpu_regfile u_regfile (
        .clk_i        (clk_i),
        .rst_i        (rst_i),
        .we_i         (rf_we),
        .wr_id_i      (rf_id),
        .wr_data_i    (rf_data),
        .rd_a_id_i    (rd_a_id),
        .rd_b_id_i    (rd_b_id),
        .rd_a_o       (rd_a),
        .rd_b_o       (rd_b),
        .pc_o         (pc)
    );

endmodule

/* src.f */
+incdir+tb
hdl/cpu_pkg.sv
hdl/cpu_dec_if.sv
hdl/cpu_res_if.sv
hdl/cpu_regfile.sv
hdl/cpu_control.sv
hdl/cpu_decode.sv
hdl/cpu_execute.sv
hdl/cpu_result.sv
hdl/cpu_top.sv
tb/cpu_tb.sv

/* tb/cpu_ref_model.svh */
`ifndef CPU_REF_MODEL_SVH
`define CPU_REF_MODEL_SVH

////////////////////
// Instruction encoders

function automatic logic [63:0] enc_rro(opcode_e op, cond_e c, int ra, int rb,
                                        logic [OFF_W-1:0] off);
    logic [63:0] w;
    w = '0;
    w[OPC_MSB:OPC_LSB]   = op;
    w[FMT_MSB:FMT_LSB]   = FMT_RRO;
    w[COND_MSB:COND_LSB] = c;
    w[RA_MSB:RA_LSB]     = ra[REG_ID_W-1:0];
    w[RB_MSB:RB_LSB]     = rb[REG_ID_W-1:0];
    w[OFF_MSB:OFF_LSB]   = off;
    return w;
endfunction

function automatic logic [63:0] enc_ris(opcode_e op, cond_e c, int ra,
                                        logic [IMM_W-1:0] imm, int sh);
    logic [63:0] w;
    w = '0;
    w[OPC_MSB:OPC_LSB]     = op;
    w[FMT_MSB:FMT_LSB]     = FMT_RIS;
    w[COND_MSB:COND_LSB]   = c;
    w[RA_MSB:RA_LSB]       = ra[REG_ID_W-1:0];
    w[IMM_MSB:IMM_LSB]     = imm;
    w[SHAMT_MSB:SHAMT_LSB] = sh[SHAMT_W-1:0];
    return w;
endfunction

function automatic logic [63:0] enc_i(opcode_e op, cond_e c, logic [JIMM_W-1:0] jimm);
    logic [63:0] w;
    w = '0;
    w[OPC_MSB:OPC_LSB]   = op;
    w[FMT_MSB:FMT_LSB]   = FMT_I;
    w[COND_MSB:COND_LSB] = c;
    w[JIMM_MSB:JIMM_LSB] = jimm;
    return w;
endfunction

////////////////////
// Reference model, one instruction per call

function automatic int ref_step();
    logic [63:0] w;
    logic [63:0] a;
    logic [63:0] b;
    logic [63:0] imm;
    logic [63:0] off;
    logic [3:0]  c;
    opcode_e     op;
    int          ra;
    int          rb;
    int          sh;
    logic        run;
    w = ref_mem[word_idx(ref_regs[REG_PC])];
    ref_regs[REG_PC] = ref_regs[REG_PC] + BYTES_PER_WORD;
    op  = opcode_e'(w[OPC_MSB:OPC_LSB]);
    c   = w[COND_MSB:COND_LSB];
    ra  = w[RA_MSB:RA_LSB];
    rb  = w[RB_MSB:RB_LSB];
    sh  = w[SHAMT_MSB:SHAMT_LSB];
    imm = {23'd0, w[IMM_MSB:IMM_LSB]};
    off = {23'd0, w[OFF_MSB:OFF_LSB]};
    a   = ref_regs[ra];
    b   = ref_regs[rb];
    run = (c == COND_Z) ? ref_zero : (c == COND_NZ) ? !ref_zero : 1'b1;
    if (!run) return EFF_NONE;
    case (op)
        OP_SET:     ref_regs[ra] = (w[FMT_MSB:FMT_LSB] == FMT_RIS) ? imm << sh : b;
        OP_SHIFTL:  ref_regs[ra] = a << imm;
        OP_OR:      ref_regs[ra] = a | b;
        OP_AND:     ref_regs[ra] = a & b;
        OP_XOR:     ref_regs[ra] = a ^ b;
        OP_SUB: begin
            ref_regs[ra] = a - imm;
            ref_zero     = (ref_regs[ra] == 64'd0);
        end
        OP_TESTBIT: ref_zero = (imm >= 64) ? 1'b1 : !a[imm[5:0]];  // Set when bit clear
        OP_JUMP: begin
            ref_regs[REG_PC] = (w[FMT_MSB:FMT_LSB] == FMT_I) ? {13'd0, w[JIMM_MSB:JIMM_LSB]} : a;
        end
        OP_LOAD: begin
            exp_adr      = b + off;
            ref_regs[ra] = ref_mem[word_idx(exp_adr)];
            return EFF_LOAD;
        end
        OP_STORE: begin
            exp_adr = a + off;
            exp_dat = b;
            ref_mem[word_idx(exp_adr)] = b;
            return EFF_STORE;
        end
        OP_HALT:    return EFF_HALT;
        default: ;
    endcase
    return EFF_NONE;
endfunction

`endif

/* tb/cpu_tb.sv */
`timescale 1ns/1ps

module cpu_tb import cpu_pkg::*; ();

    localparam int EFF_NONE  = 0;
    localparam int EFF_LOAD  = 1;
    localparam int EFF_STORE = 2;
    localparam int EFF_HALT  = 3;
    localparam logic [63:0] DATA_BASE = PC_RESET + 64'h400;

    logic        clk_i = 1'b0;
    logic        rst_i = 1'b1;
    logic        halted_o;
    logic        bus_cyc_o;
    logic        bus_stb_o;
    logic        bus_we_o;
    logic [7:0]  bus_sel_o;
    logic [63:0] bus_adr_o;
    logic [63:0] bus_dat_o;
    logic [63:0] bus_dat_i = '0;
    logic        bus_ack_i = 1'b0;
    logic        bus_err_i = 1'b0;

    logic [63:0] mem [0:255];      // Bus side memory
    logic [63:0] ref_mem [0:255];  // Model memory
    logic [63:0] img [0:255];
    int          img_len;
    logic [63:0] ref_regs [0:31];
    logic        ref_zero;
    logic        ref_done;
    logic        data_phase;
    int          exp_kind;
    logic [63:0] exp_adr;
    logic [63:0] exp_dat;
    logic [31:0] rng = 32'h2dbd_e992;
    int          wait_left;
    logic        pending;
    int          err_cnt = 0;
    int          pass_cnt = 0;
    int          fail_cnt = 0;
    longint      cycle_cnt = 0;
    longint      cycle_limit = 1000;
    string       cur_test;

    function automatic int word_idx(logic [63:0] adr);
        return adr[10:3];
    endfunction

    function automatic logic adr_ok(logic [63:0] adr);
        return (adr[63:11] == PC_RESET[63:11]) && (adr[2:0] == 3'd0);
    endfunction

    function automatic logic [31:0] xorshift();
        rng = rng ^ (rng << 13);
        rng = rng ^ (rng >> 17);
        rng = rng ^ (rng << 5);
        return rng;
    endfunction

    `include "cpu_ref_model.svh"

    cpu_top cpu_top_inst (.*);

    always #50 clk_i = ~clk_i;

    ////////////////////
    // Memory model with random ack delay

    always @(posedge clk_i) begin
        #1;
        if (rst_i || !bus_cyc_o || !bus_stb_o) begin
            bus_ack_i = 1'b0;
            bus_err_i = 1'b0;
            pending   = 1'b0;
        end else if (!bus_ack_i && !bus_err_i) begin
            if (!pending) begin
                pending   = 1'b1;
                wait_left = xorshift() % 4;
            end
            if (wait_left > 0) begin
                wait_left--;
            end else if (!adr_ok(bus_adr_o)) begin
                bus_err_i = 1'b1;
            end else begin
                bus_ack_i = 1'b1;
                if (bus_we_o) mem[word_idx(bus_adr_o)] = bus_dat_o;
                bus_dat_i = mem[word_idx(bus_adr_o)];
            end
        end
    end

    task automatic mismatch(string what, logic [63:0] exp, logic [63:0] act);
        $display("MISMATCH %s %s expected %h actual %h", cur_test, what, exp, act);
        err_cnt++;
    endtask

    ////////////////////
    // Comparison against the model

    always @(negedge clk_i) begin
        if (!rst_i && bus_cyc_o && bus_stb_o && (bus_ack_i || bus_err_i)) begin
            if (bus_sel_o != 8'hff) begin
                mismatch("sel", 8'hff, bus_sel_o);  // Full word lanes
            end
            if (ref_done) begin
                $display("%s: bus transfer after the CPU should have stopped", cur_test);
                err_cnt++;
            end else if (!data_phase) begin
                if (bus_adr_o != ref_regs[REG_PC]) begin
                    mismatch("fetch_adr", ref_regs[REG_PC], bus_adr_o);
                end
                if (bus_we_o) begin
                    mismatch("fetch_we", 0, bus_we_o);
                end
                if (bus_err_i) begin
                    ref_done = 1'b1;  // Fetch error halts
                end else begin
                    exp_kind   = ref_step();
                    ref_done   = (exp_kind == EFF_HALT);
                    data_phase = (exp_kind == EFF_LOAD) || (exp_kind == EFF_STORE);
                end
            end else begin
                data_phase = 1'b0;
                if (bus_adr_o != exp_adr) begin
                    mismatch("data_adr", exp_adr, bus_adr_o);
                end
                if (bus_we_o != (exp_kind == EFF_STORE)) begin
                    mismatch("data_we", exp_kind == EFF_STORE, bus_we_o);
                end
                if ((exp_kind == EFF_STORE) && (bus_dat_o != exp_dat)) begin
                    mismatch("store_dat", exp_dat, bus_dat_o);
                end
            end
        end
    end

    // Watchdog
    always @(posedge clk_i) begin
        cycle_cnt++;
        if (cycle_cnt > cycle_limit) begin
            $display("Timeout in test %s, the CPU did not halt", cur_test);
            $display("TESTS FAILED");
            $finish;
        end
    end

    task automatic emit(logic [63:0] w);
        img[img_len] = w;
        img_len++;
    endtask

    function automatic logic [JIMM_W-1:0] target(int idx);
        return JIMM_W'(PC_RESET + idx * 8);
    endfunction

    ////////////////////
    // Programs

    task automatic build_program(int id);
        for (int i = 0; i < 256; i++) img[i] = '0;
        img_len = 0;
        case (id)
            0: begin
                cur_test = "fetch_seq";
                repeat (4) emit(enc_rro(OP_NOP, COND_ALWAYS, 0, 0, 0));
                emit(enc_rro(OP_HALT, COND_ALWAYS, 0, 0, 0));
            end
            1: begin
                cur_test = "alu_ops";
                emit(enc_ris(OP_SET, COND_ALWAYS, 1, IMM_W'(DATA_BASE >> 10), 10));  // Data base
                emit(enc_ris(OP_SET, COND_ALWAYS, 2, 41'h1234_5678, 8));
                emit(enc_rro(OP_STORE, COND_ALWAYS, 1, 2, 41'h0));
                emit(enc_ris(OP_SUB, COND_ALWAYS, 2, 41'h78, 0));
                emit(enc_rro(OP_STORE, COND_ALWAYS, 1, 2, 41'h8));
                emit(enc_ris(OP_SHIFTL, COND_ALWAYS, 2, 41'h4, 0));
                emit(enc_rro(OP_STORE, COND_ALWAYS, 1, 2, 41'h10));
                emit(enc_ris(OP_SET, COND_ALWAYS, 3, 41'hff_00ff, 3));
                emit(enc_rro(OP_SET, COND_ALWAYS, 4, 2, 0));
                emit(enc_rro(OP_OR, COND_ALWAYS, 4, 3, 0));
                emit(enc_rro(OP_STORE, COND_ALWAYS, 1, 4, 41'h18));
                emit(enc_rro(OP_AND, COND_ALWAYS, 4, 3, 0));
                emit(enc_rro(OP_STORE, COND_ALWAYS, 1, 4, 41'h20));
                emit(enc_rro(OP_XOR, COND_ALWAYS, 4, 2, 0));
                emit(enc_rro(OP_STORE, COND_ALWAYS, 1, 4, 41'h28));
                emit(enc_rro(OP_HALT, COND_ALWAYS, 0, 0, 0));
            end
            2: begin
                cur_test = "load_store";
                emit(enc_ris(OP_SET, COND_ALWAYS, 1, IMM_W'(DATA_BASE >> 10), 10));
                emit(enc_rro(OP_LOAD, COND_ALWAYS, 5, 1, 41'h40));
                emit(enc_rro(OP_LOAD, COND_ALWAYS, 6, 1, 41'h48));
                emit(enc_rro(OP_XOR, COND_ALWAYS, 5, 6, 0));
                emit(enc_rro(OP_STORE, COND_ALWAYS, 1, 5, 41'h80));
                emit(enc_rro(OP_STORE, COND_ALWAYS, 1, 6, 41'h88));
                emit(enc_rro(OP_HALT, COND_ALWAYS, 0, 0, 0));
                img[136] = {xorshift(), xorshift()};
                img[137] = {xorshift(), xorshift()};
            end
            3: begin
                cur_test = "flags_jumps";
                emit(enc_ris(OP_SET, COND_ALWAYS, 1, IMM_W'(DATA_BASE >> 10), 10));
                emit(enc_ris(OP_SET, COND_ALWAYS, 2, 41'h5, 0));
                emit(enc_ris(OP_SUB, COND_ALWAYS, 2, 41'h5, 0));      // Zero set
                emit(enc_i(OP_JUMP, COND_NZ, target(15)));            // Skipped
                emit(enc_i(OP_JUMP, COND_Z, target(6)));              // Taken
                emit(enc_rro(OP_HALT, COND_ALWAYS, 0, 0, 0));
                emit(enc_ris(OP_TESTBIT, COND_ALWAYS, 1, 41'd10, 0));  // Bit set, zero clear
                emit(enc_i(OP_JUMP, COND_Z, target(5)));
                emit(enc_ris(OP_TESTBIT, COND_ALWAYS, 1, 41'd3, 0));
                emit(enc_ris(OP_SET, COND_ALWAYS, 7, 41'h8000_0000, 16));
                emit(enc_ris(OP_SET, COND_ALWAYS, 8, 41'h70, 0));
                emit(enc_rro(OP_OR, COND_ALWAYS, 7, 8, 0));           // Address of word 14
                emit(enc_rro(OP_JUMP, COND_Z, 7, 0, 0));
                emit(enc_rro(OP_HALT, COND_ALWAYS, 0, 0, 0));
                emit(enc_rro(OP_JUMP, COND_NZ, 7, 0, 0));
                emit(enc_rro(OP_HALT, COND_ALWAYS, 0, 0, 0));
            end
            4: begin
                cur_test = "halt";
                emit(enc_rro(OP_NOP, COND_ALWAYS, 0, 0, 0));
                emit(enc_rro(OP_HALT, COND_ALWAYS, 0, 0, 0));
                emit(enc_rro(OP_NOP, COND_ALWAYS, 0, 0, 0));
            end
            default: begin
                cur_test = "bus_error";
                emit(enc_rro(OP_NOP, COND_ALWAYS, 0, 0, 0));
                emit(enc_i(OP_JUMP, COND_ALWAYS, 51'h1000));  // Unmapped
            end
        endcase
    endtask

    task automatic run_test(int id);
        int errs_before;
        errs_before = err_cnt;
        build_program(id);
        for (int i = 0; i < 256; i++) begin
            mem[i]     = img[i];
            ref_mem[i] = img[i];
        end
        for (int i = 0; i < 32; i++) ref_regs[i] = '0;
        ref_regs[REG_PC] = PC_RESET;
        ref_zero    = 1'b0;
        ref_done    = 1'b0;
        data_phase  = 1'b0;
        cycle_limit = cycle_cnt + img_len * 20 + 40;
        @(posedge clk_i);
        #1 rst_i = 1'b1;
        repeat (10) @(posedge clk_i);
        #1 rst_i = 1'b0;
        if (bus_cyc_o || bus_stb_o || bus_we_o || halted_o) begin
            $display("%s: outputs not idle after reset", cur_test);
            err_cnt++;
        end
        while (!halted_o) @(negedge clk_i);
        repeat (10) begin
            @(negedge clk_i);
            if (bus_cyc_o || bus_stb_o) begin
                $display("%s: bus still active after halt", cur_test);
                err_cnt++;
            end
        end
        if (!ref_done) begin
            $display("%s: CPU halted before the model reached a halt", cur_test);
            err_cnt++;
        end
        if (err_cnt == errs_before) begin
            pass_cnt++;
            $display("%s: pass", cur_test);
        end else begin
            fail_cnt++;
            $display("%s: fail", cur_test);
        end
    endtask

    initial begin
        for (int t = 0; t < 6; t++) run_test(t);
        $display("%0d passed, %0d failed", pass_cnt, fail_cnt);
        if (fail_cnt == 0) begin
            $display("TESTS PASSED");
        end else begin
            $display("TESTS FAILED");
        end
        $finish;
    end

endmodule
